//--- rtl/kalman_defines.svh
`ifndef KALMAN_DEFINES_SVH
`define KALMAN_DEFINES_SVH

// Size of the resonator bank and of the fixed-point words.
`define KALMAN_HARMONICS 4
`define KALMAN_SAMPLE_W 18
`define KALMAN_FRAC 16

// AXI4-Lite write port geometry.
`define KALMAN_AXIL_AW 8
`define KALMAN_AXIL_DW 32

// Register map. A write to the sample address starts one update.
// In the coefficient region, address bits 5:4 pick the harmonic and bits 3:2 the field.
`define KALMAN_ADDR_SAMPLE 8'h00
`define KALMAN_COEF_BASE 8'h40

`endif

//--- rtl/kalman_fix_pkg.sv
`default_nettype none

`include "kalman_defines.svh"

package kalman_fix_pkg;

	// Samples, the error and every state share one signed width.
	typedef logic signed [`KALMAN_SAMPLE_W-1:0] sample_t;

	// Coefficients are Q1.16 in the same 18-bit word.
	typedef logic signed [`KALMAN_SAMPLE_W-1:0] coef_t;

	typedef struct packed {
		coef_t cos;
		coef_t sin;
		coef_t k1;
		coef_t k2;
	} coef_set_t;

	typedef struct packed {
		sample_t x1;
		sample_t x2;
	} state_pair_t;

	// Wide enough for an 18x18 product plus headroom for the sums.
	typedef logic signed [39:0] acc_t;

endpackage

`default_nettype wire

//--- rtl/kalman_ctrl_pkg.sv
`default_nettype none

`include "kalman_defines.svh"

package kalman_ctrl_pkg;

	// SUM ops gather the first states, UPDATE ops advance one resonator.
	typedef enum logic {
		OP_SUM,
		OP_UPDATE
	} op_kind_e;

	typedef logic [$clog2(`KALMAN_HARMONICS)-1:0] harm_idx_t;

	// Order matches address bits 3:2 of the coefficient region.
	typedef enum logic [1:0] {
		FIELD_COS,
		FIELD_SIN,
		FIELD_K1,
		FIELD_K2
	} coef_field_e;

endpackage

`default_nettype wire

//--- rtl/kalman_if.sv
`default_nettype none

// ************************************************************
// Operation bus from the sequencer to the MAC.
// ************************************************************
interface kalman_op_if;

	logic valid;
	kalman_ctrl_pkg::op_kind_e kind;
	kalman_ctrl_pkg::harm_idx_t harm;
	// Marks the last harmonic of the current phase.
	logic last;

	modport src (output valid, kind, harm, last);
	modport snk (input valid, kind, harm, last);

endinterface

// ************************************************************
// Result bus from the MAC to the state bank.
// ************************************************************
interface kalman_res_if;

	logic valid;
	kalman_ctrl_pkg::harm_idx_t harm;
	kalman_fix_pkg::state_pair_t pair;
	logic last;

	modport src (output valid, harm, pair, last);
	modport snk (input valid, harm, pair, last);

endinterface

`default_nettype wire

//--- rtl/kalman_host_port.sv
`default_nettype none

`include "kalman_defines.svh"

module kalman_host_port (
	input wire clk_i,
	input wire harmonics_rst,
	input wire s_awvalid_i,
	input wire [`KALMAN_AXIL_AW-1:0] s_awaddr_i,
	input wire s_wvalid_i,
	input wire [`KALMAN_AXIL_DW-1:0] s_wdata_i,
	input wire [`KALMAN_AXIL_DW/8-1:0] s_wstrb_i,
	input wire s_bready_i,
	input wire busy_i,
	output logic s_awready_o,
	output logic s_wready_o,
	output logic s_bvalid_o,
	output logic [1:0] s_bresp_o,
	output logic start_o,
	output kalman_fix_pkg::sample_t sample_o,
	output kalman_fix_pkg::coef_set_t coefs_o [`KALMAN_HARMONICS]
);

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam logic [`KALMAN_AXIL_AW-1:0] ADDR_SAMPLE = `KALMAN_ADDR_SAMPLE;
	localparam logic [`KALMAN_AXIL_AW-1:0] COEF_BASE = `KALMAN_COEF_BASE;
	localparam int AW = `KALMAN_AXIL_AW;
	localparam int SW = `KALMAN_SAMPLE_W;

	logic wr_fire;
	logic sample_hit;
	logic coef_hit;
	logic [1:0] wr_resp;
	kalman_ctrl_pkg::harm_idx_t wr_harm;
	kalman_ctrl_pkg::coef_field_e wr_field;
	kalman_fix_pkg::coef_t wr_coef;

	// Both channels complete in the same cycle.
	assign wr_fire = s_awvalid_i && s_awready_o && s_wvalid_i && s_wready_o;

	// Byte offset bits are not decoded, every register is written whole.
	// The write strobe s_wstrb_i is accepted but has no effect.
	assign sample_hit = (s_awaddr_i[AW-1:2] == ADDR_SAMPLE[AW-1:2]);
	assign coef_hit = (s_awaddr_i[AW-1:6] == COEF_BASE[AW-1:6]);
	assign wr_harm = s_awaddr_i[5:4];
	assign wr_field = kalman_ctrl_pkg::coef_field_e'(s_awaddr_i[3:2]);
	assign wr_coef = s_wdata_i[SW-1:0];

	// A sample that arrives during an update is refused.
	assign wr_resp = (coef_hit || (sample_hit && !busy_i)) ? RESP_OKAY : RESP_SLVERR;

	// Start is combinational so that busy follows in the very next cycle.
	assign start_o = wr_fire && sample_hit && !busy_i;

	// ************************************************************
	// Handshake and response.
	// ************************************************************
	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			s_awready_o <= 1'b0;
			s_wready_o <= 1'b0;
			s_bvalid_o <= 1'b0;
			s_bresp_o <= RESP_OKAY;
		end else begin
			s_awready_o <= 1'b0;
			s_wready_o <= 1'b0;
			if (s_awvalid_i && s_wvalid_i && !s_awready_o && !s_bvalid_o) begin
				s_awready_o <= 1'b1;
				s_wready_o <= 1'b1;
			end
			if (wr_fire) begin
				s_bvalid_o <= 1'b1;
				s_bresp_o <= wr_resp;
			end else if (s_bready_i) begin
				s_bvalid_o <= 1'b0;
			end
		end
	end

	// ************************************************************
	// Register file.
	// ************************************************************
	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			sample_o <= '0;
			for (int h = 0; h < `KALMAN_HARMONICS; h++) begin
				coefs_o[h] <= '0;
			end
		end else if (wr_fire) begin
			if (start_o) begin
				sample_o <= s_wdata_i[SW-1:0];
			end
			if (coef_hit) begin
				case (wr_field)
					kalman_ctrl_pkg::FIELD_COS: coefs_o[wr_harm].cos <= wr_coef;
					kalman_ctrl_pkg::FIELD_SIN: coefs_o[wr_harm].sin <= wr_coef;
					kalman_ctrl_pkg::FIELD_K1: coefs_o[wr_harm].k1 <= wr_coef;
					default: coefs_o[wr_harm].k2 <= wr_coef;
				endcase
			end
		end
	end

	// A response, once raised, keeps its code until the host takes it.
	a_bresp_held: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

endmodule

`default_nettype wire

//--- rtl/kalman_sequencer.sv
`default_nettype none

`include "kalman_defines.svh"

module kalman_sequencer (
	input wire clk_i,
	input wire harmonics_rst,
	input wire start_i,
	input wire err_ready_i,
	input wire update_done_i,
	output logic busy_o,
	kalman_op_if.src op
);

	localparam kalman_ctrl_pkg::harm_idx_t LAST_HARM =
		kalman_ctrl_pkg::harm_idx_t'(`KALMAN_HARMONICS - 1);

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_SUM,
		PH_WAIT_ERR,
		PH_UPDATE,
		PH_DRAIN
	} phase_e;

	phase_e phase_q;
	kalman_ctrl_pkg::harm_idx_t harm_q;

	// Ops are issued straight from the phase and the harmonic counter.
	assign op.valid = (phase_q == PH_SUM) || (phase_q == PH_UPDATE);
	assign op.kind = (phase_q == PH_UPDATE) ? kalman_ctrl_pkg::OP_UPDATE
		: kalman_ctrl_pkg::OP_SUM;
	assign op.harm = harm_q;
	assign op.last = (harm_q == LAST_HARM);

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			phase_q <= PH_IDLE;
			harm_q <= '0;
			busy_o <= 1'b0;
		end else begin
			case (phase_q)
				PH_IDLE: begin
					harm_q <= '0;
					if (start_i) begin
						phase_q <= PH_SUM;
						busy_o <= 1'b1;
					end
				end
				PH_SUM: begin
					harm_q <= harm_q + 1'b1;
					if (harm_q == LAST_HARM) begin
						phase_q <= PH_WAIT_ERR;
						harm_q <= '0;
					end
				end
				PH_WAIT_ERR: begin
					if (err_ready_i) begin
						phase_q <= PH_UPDATE;
					end
				end
				PH_UPDATE: begin
					harm_q <= harm_q + 1'b1;
					if (harm_q == LAST_HARM) begin
						phase_q <= PH_DRAIN;
					end
				end
				default: begin
					// Results are still in the MAC pipeline here.
					if (update_done_i) begin
						phase_q <= PH_IDLE;
						busy_o <= 1'b0;
					end
				end
			endcase
		end
	end

	// The MAC must hold a fresh error before any resonator moves.
	a_update_after_err: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		op.valid && op.kind == kalman_ctrl_pkg::OP_UPDATE |-> err_ready_i);

endmodule

`default_nettype wire

//--- rtl/kalman_mac.sv
`default_nettype none

`include "kalman_defines.svh"

module kalman_mac (
	input wire clk_i,
	input wire harmonics_rst,
	kalman_op_if.snk op,
	input kalman_fix_pkg::sample_t sample_i,
	input kalman_fix_pkg::coef_set_t coefs_i [`KALMAN_HARMONICS],
	input kalman_fix_pkg::state_pair_t states_i [`KALMAN_HARMONICS],
	kalman_res_if.src res,
	output logic err_ready_o
);

	localparam int W = `KALMAN_SAMPLE_W;
	localparam int FRAC = `KALMAN_FRAC;
	localparam kalman_fix_pkg::acc_t SAT_MAX = (kalman_fix_pkg::acc_t'(1) <<< (W - 1)) - 1;
	localparam kalman_fix_pkg::acc_t SAT_MIN = -(kalman_fix_pkg::acc_t'(1) <<< (W - 1));

	logic sum_op;
	logic upd_op;
	kalman_fix_pkg::coef_set_t coef_sel;
	kalman_fix_pkg::state_pair_t cur;
	kalman_fix_pkg::acc_t sum_next;
	kalman_fix_pkg::acc_t err_next;
	kalman_fix_pkg::acc_t acc_q;
	kalman_fix_pkg::sample_t err_q;
	kalman_fix_pkg::acc_t p_cx1_q, p_sx2_q, p_sx1_q, p_cx2_q, p_k1e_q, p_k2e_q;
	kalman_fix_pkg::acc_t rot1, rot2, x1_sum, x2_sum;
	kalman_ctrl_pkg::harm_idx_t harm1_q;
	logic last1_q;
	logic v1_q;

	// Clamp to the signed state range.
	function automatic kalman_fix_pkg::sample_t saturate(input kalman_fix_pkg::acc_t v);
		if (v > SAT_MAX) begin
			return SAT_MAX[W-1:0];
		end else if (v < SAT_MIN) begin
			return SAT_MIN[W-1:0];
		end
		return v[W-1:0];
	endfunction

	assign sum_op = op.valid && (op.kind == kalman_ctrl_pkg::OP_SUM);
	assign upd_op = op.valid && (op.kind == kalman_ctrl_pkg::OP_UPDATE);
	assign coef_sel = coefs_i[op.harm];
	assign cur = states_i[op.harm];

	// ************************************************************
	// Sum of first states and the error.
	// ************************************************************
	always_comb begin
		// Harmonic 0 opens a new sum.
		if (op.harm == '0) begin
			sum_next = kalman_fix_pkg::acc_t'(cur.x1);
		end else begin
			sum_next = acc_q + kalman_fix_pkg::acc_t'(cur.x1);
		end
		err_next = kalman_fix_pkg::acc_t'(sample_i) - sum_next;
	end

	// ************************************************************
	// Second stage arithmetic.
	// ************************************************************
	always_comb begin
		rot1 = (p_cx1_q - p_sx2_q) >>> FRAC;
		rot2 = (p_sx1_q + p_cx2_q) >>> FRAC;
		// Rotation is clamped first, then the gain term is added and clamped again.
		x1_sum = kalman_fix_pkg::acc_t'(saturate(rot1)) + (p_k1e_q >>> FRAC);
		x2_sum = kalman_fix_pkg::acc_t'(saturate(rot2)) + (p_k2e_q >>> FRAC);
	end

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			v1_q <= 1'b0;
			res.valid <= 1'b0;
			err_ready_o <= 1'b0;
		end else begin
			v1_q <= upd_op;
			res.valid <= v1_q;
			// Rises after the last SUM op and drops after the first of the next update.
			if (sum_op) begin
				err_ready_o <= op.last;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (sum_op) begin
			acc_q <= sum_next;
			if (op.last) begin
				err_q <= saturate(err_next);
			end
		end
		// Stage one: six products of one harmonic.
		if (upd_op) begin
			p_cx1_q <= coef_sel.cos * cur.x1;
			p_sx2_q <= coef_sel.sin * cur.x2;
			p_sx1_q <= coef_sel.sin * cur.x1;
			p_cx2_q <= coef_sel.cos * cur.x2;
			p_k1e_q <= coef_sel.k1 * err_q;
			p_k2e_q <= coef_sel.k2 * err_q;
			harm1_q <= op.harm;
			last1_q <= op.last;
		end
		// Stage two: the new state pair.
		if (v1_q) begin
			res.harm <= harm1_q;
			res.last <= last1_q;
			res.pair.x1 <= saturate(x1_sum);
			res.pair.x2 <= saturate(x2_sum);
		end
	end

endmodule

`default_nettype wire

//--- rtl/kalman_state_bank.sv
`default_nettype none

`include "kalman_defines.svh"

module kalman_state_bank (
	input wire clk_i,
	input wire harmonics_rst,
	kalman_res_if.snk res,
	output kalman_fix_pkg::state_pair_t states_o [`KALMAN_HARMONICS],
	output logic update_done_o,
	output logic state_we_o,
	output kalman_ctrl_pkg::harm_idx_t state_harm_o,
	output kalman_fix_pkg::sample_t state_x1_o,
	output kalman_fix_pkg::sample_t state_x2_o
);

	// State register file and stream strobes.
	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			state_we_o <= 1'b0;
			update_done_o <= 1'b0;
			for (int h = 0; h < `KALMAN_HARMONICS; h++) begin
				states_o[h] <= '0;
			end
		end else begin
			state_we_o <= res.valid;
			update_done_o <= res.valid && res.last;
			if (res.valid) begin
				states_o[res.harm] <= res.pair;
			end
		end
	end

	// Stream payload, qualified by state_we_o.
	always_ff @(posedge clk_i) begin
		if (res.valid) begin
			state_harm_o <= res.harm;
			state_x1_o <= res.pair.x1;
			state_x2_o <= res.pair.x2;
		end
	end

	// A burst of results opens with harmonic 0.
	a_first_harm: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		res.valid && !$past(res.valid) |-> res.harm == '0);

	// Each following beat carries the next harmonic.
	a_harm_order: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		res.valid && !res.last |=>
			res.valid && res.harm == kalman_ctrl_pkg::harm_idx_t'($past(res.harm) + 1'b1));

endmodule

`default_nettype wire

//--- rtl/kalman_top.sv
`default_nettype none

`include "kalman_defines.svh"

module kalman_top (
	input wire clk_i,
	input wire harmonics_rst,
	input wire s_awvalid_i,
	output logic s_awready_o,
	input wire [`KALMAN_AXIL_AW-1:0] s_awaddr_i,
	input wire s_wvalid_i,
	output logic s_wready_o,
	input wire [`KALMAN_AXIL_DW-1:0] s_wdata_i,
	input wire [`KALMAN_AXIL_DW/8-1:0] s_wstrb_i,
	output logic s_bvalid_o,
	input wire s_bready_i,
	output logic [1:0] s_bresp_o,
	output logic busy_o,
	output logic state_we_o,
	output kalman_ctrl_pkg::harm_idx_t state_harm_o,
	output kalman_fix_pkg::sample_t state_x1_o,
	output kalman_fix_pkg::sample_t state_x2_o
);

	logic start;
	logic err_ready;
	logic update_done;
	kalman_fix_pkg::sample_t sample;
	kalman_fix_pkg::coef_set_t coefs [`KALMAN_HARMONICS];
	kalman_fix_pkg::state_pair_t states [`KALMAN_HARMONICS];

	kalman_op_if op_bus ();
	kalman_res_if res_bus ();

	// ************************************************************
	// Host port, then decode, execute and result stages.
	// ************************************************************
	kalman_host_port u_host_port (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.s_awvalid_i(s_awvalid_i),
		.s_awaddr_i(s_awaddr_i),
		.s_wvalid_i(s_wvalid_i),
		.s_wdata_i(s_wdata_i),
		.s_wstrb_i(s_wstrb_i),
		.s_bready_i(s_bready_i),
		.busy_i(busy_o),
		.s_awready_o(s_awready_o),
		.s_wready_o(s_wready_o),
		.s_bvalid_o(s_bvalid_o),
		.s_bresp_o(s_bresp_o),
		.start_o(start),
		.sample_o(sample),
		.coefs_o(coefs)
	);

	kalman_sequencer u_sequencer (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.start_i(start),
		.err_ready_i(err_ready),
		.update_done_i(update_done),
		.busy_o(busy_o),
		.op(op_bus)
	);

	kalman_mac u_mac (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.op(op_bus),
		.sample_i(sample),
		.coefs_i(coefs),
		.states_i(states),
		.res(res_bus),
		.err_ready_o(err_ready)
	);

	kalman_state_bank u_state_bank (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.res(res_bus),
		.states_o(states),
		.update_done_o(update_done),
		.state_we_o(state_we_o),
		.state_harm_o(state_harm_o),
		.state_x1_o(state_x1_o),
		.state_x2_o(state_x2_o)
	);

endmodule

`default_nettype wire

//--- tb/kalman_tb.sv
`default_nettype none

`include "kalman_defines.svh"

module kalman_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int HN = `KALMAN_HARMONICS;
	localparam int FRAC = `KALMAN_FRAC;
	localparam int STIM_N = 9;
	localparam int WAIT_LIMIT = 200;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam longint SAT_HI = (longint'(1) <<< (`KALMAN_SAMPLE_W - 1)) - 1;
	localparam longint SAT_LO = -(longint'(1) <<< (`KALMAN_SAMPLE_W - 1));

	// Profile 0 keeps the coefficients that are loaded already.
	typedef struct packed {
		int prof;
		bit rnd;
		int value;
		bit poke;
	} stim_row_t;

	logic clk_i;
	logic harmonics_rst;
	logic s_awvalid_i;
	logic s_awready_o;
	logic [`KALMAN_AXIL_AW-1:0] s_awaddr_i;
	logic s_wvalid_i;
	logic s_wready_o;
	logic [`KALMAN_AXIL_DW-1:0] s_wdata_i;
	logic [`KALMAN_AXIL_DW/8-1:0] s_wstrb_i;
	logic s_bvalid_o;
	logic s_bready_i;
	logic [1:0] s_bresp_o;
	logic busy_o;
	logic state_we_o;
	kalman_ctrl_pkg::harm_idx_t state_harm_o;
	kalman_fix_pkg::sample_t state_x1_o;
	kalman_fix_pkg::sample_t state_x2_o;

	stim_row_t stim [STIM_N];
	kalman_ctrl_pkg::harm_idx_t got_harm [$];
	kalman_fix_pkg::state_pair_t got_pair [$];
	longint mx1 [HN];
	longint mx2 [HN];
	longint mcos [HN];
	longint msin [HN];
	longint mk1 [HN];
	longint mk2 [HN];
	kalman_fix_pkg::state_pair_t exp_pair [HN];
	int clamp_hits;

	kalman_top UUT (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.s_awvalid_i(s_awvalid_i),
		.s_awready_o(s_awready_o),
		.s_awaddr_i(s_awaddr_i),
		.s_wvalid_i(s_wvalid_i),
		.s_wready_o(s_wready_o),
		.s_wdata_i(s_wdata_i),
		.s_wstrb_i(s_wstrb_i),
		.s_bvalid_o(s_bvalid_o),
		.s_bready_i(s_bready_i),
		.s_bresp_o(s_bresp_o),
		.busy_o(busy_o),
		.state_we_o(state_we_o),
		.state_harm_o(state_harm_o),
		.state_x1_o(state_x1_o),
		.state_x2_o(state_x2_o)
	);

	always #5 clk_i = ~clk_i;

	// The stream monitor samples away from the rising edge.
	always @(negedge clk_i) begin
		if (!harmonics_rst && state_we_o) begin
			got_harm.push_back(state_harm_o);
			got_pair.push_back({state_x1_o, state_x2_o});
		end
	end

	// ************************************************************
	// Checks and error handling.
	// ************************************************************
	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp) begin
			fail_stop($sformatf("MISMATCH at %0t: %s gave response %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	task automatic check_state(input kalman_ctrl_pkg::harm_idx_t got_h,
		input kalman_ctrl_pkg::harm_idx_t exp_h, input kalman_fix_pkg::state_pair_t got,
		input kalman_fix_pkg::state_pair_t exp, input string what);
		if (got_h !== exp_h || got !== exp) begin
			fail_stop($sformatf("MISMATCH at %0t: %s harm %0d x1 %0d x2 %0d, expected %0d %0d %0d",
				$time, what, got_h, got.x1, got.x2, exp_h, exp.x1, exp.x2));
		end
	endtask

	task automatic check_busy(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			fail_stop($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	// ************************************************************
	// Stimulus helpers.
	// ************************************************************
	function automatic kalman_fix_pkg::coef_t to_coef(input int v);
		return kalman_fix_pkg::coef_t'(v);
	endfunction

	function automatic logic [`KALMAN_AXIL_DW-1:0] to_word(
		input logic signed [`KALMAN_SAMPLE_W-1:0] v);
		return {{(`KALMAN_AXIL_DW - `KALMAN_SAMPLE_W){v[`KALMAN_SAMPLE_W-1]}}, v};
	endfunction

	function automatic kalman_fix_pkg::coef_set_t coef_profile(input int prof, input int h);
		kalman_fix_pkg::coef_set_t c;
		case (prof)
			1: begin
				// Unit rotation and no gain hold every state where it is.
				c.cos = to_coef(65536);
				c.sin = to_coef(0);
				c.k1 = to_coef(0);
				c.k2 = to_coef(0);
			end
			2: begin
				c.cos = to_coef(60000 - h * 5000);
				c.sin = to_coef(25000 + h * 4000);
				c.k1 = to_coef(9000 + h * 2000);
				c.k2 = to_coef(4000 - h * 3000);
			end
			default: begin
				// Near full scale, so the states run into the clamp.
				c.cos = to_coef(130000);
				c.sin = to_coef(h * 30000 - 120000);
				c.k1 = to_coef(131071);
				c.k2 = to_coef(h * 7000 - 131072);
			end
		endcase
		return c;
	endfunction

	function automatic longint sat_limit(input longint v);
		if (v > SAT_HI) begin
			return SAT_HI;
		end else if (v < SAT_LO) begin
			return SAT_LO;
		end
		return v;
	endfunction

	task automatic axi_write(input logic [`KALMAN_AXIL_AW-1:0] addr,
		input logic [`KALMAN_AXIL_DW-1:0] data, output logic [1:0] resp);
		int n;
		@(negedge clk_i);
		s_awvalid_i = 1'b1;
		s_awaddr_i = addr;
		s_wvalid_i = 1'b1;
		s_wdata_i = data;
		n = 0;
		while (!(s_awready_o && s_wready_o)) begin
			@(negedge clk_i);
			n++;
			if (n > WAIT_LIMIT) begin
				fail_stop("Timeout: the slave never raised awready and wready.");
			end
		end
		// Both channels complete at the next rising edge.
		@(negedge clk_i);
		s_awvalid_i = 1'b0;
		s_wvalid_i = 1'b0;
		s_bready_i = 1'b1;
		n = 0;
		while (!s_bvalid_o) begin
			@(negedge clk_i);
			n++;
			if (n > WAIT_LIMIT) begin
				fail_stop("Timeout: the write response never arrived.");
			end
		end
		resp = s_bresp_o;
		@(negedge clk_i);
		s_bready_i = 1'b0;
	endtask

	task automatic write_coefs(input int prof);
		kalman_fix_pkg::coef_set_t c;
		kalman_fix_pkg::coef_t v;
		logic [`KALMAN_AXIL_AW-1:0] addr;
		logic [1:0] resp;
		for (int h = 0; h < HN; h++) begin
			c = coef_profile(prof, h);
			mcos[h] = longint'(c.cos);
			msin[h] = longint'(c.sin);
			mk1[h] = longint'(c.k1);
			mk2[h] = longint'(c.k2);
			for (int f = 0; f < 4; f++) begin
				case (kalman_ctrl_pkg::coef_field_e'(f[1:0]))
					kalman_ctrl_pkg::FIELD_COS: v = c.cos;
					kalman_ctrl_pkg::FIELD_SIN: v = c.sin;
					kalman_ctrl_pkg::FIELD_K1: v = c.k1;
					default: v = c.k2;
				endcase
				addr = `KALMAN_COEF_BASE;
				addr[5:4] = h[1:0];
				addr[3:2] = f[1:0];
				axi_write(addr, to_word(v), resp);
				check_resp(resp, RESP_OKAY, "Coefficient write");
			end
		end
	endtask

	// ************************************************************
	// Reference model of one update.
	// ************************************************************
	task automatic model_update(input kalman_fix_pkg::sample_t s);
		longint sum;
		longint err;
		longint n1;
		longint n2;
		sum = 0;
		for (int h = 0; h < HN; h++) begin
			sum += mx1[h];
		end
		err = sat_limit(longint'(s) - sum);
		for (int h = 0; h < HN; h++) begin
			n1 = sat_limit(sat_limit((mcos[h] * mx1[h] - msin[h] * mx2[h]) >>> FRAC)
				+ ((mk1[h] * err) >>> FRAC));
			n2 = sat_limit(sat_limit((msin[h] * mx1[h] + mcos[h] * mx2[h]) >>> FRAC)
				+ ((mk2[h] * err) >>> FRAC));
			mx1[h] = n1;
			mx2[h] = n2;
			exp_pair[h].x1 = kalman_fix_pkg::sample_t'(n1);
			exp_pair[h].x2 = kalman_fix_pkg::sample_t'(n2);
			if (n1 == SAT_HI || n1 == SAT_LO || n2 == SAT_HI || n2 == SAT_LO) begin
				clamp_hits++;
			end
		end
	endtask

	task automatic wait_idle(output logic we_before);
		int n;
		n = 0;
		we_before = 1'b0;
		while (busy_o) begin
			we_before = state_we_o;
			@(negedge clk_i);
			n++;
			if (n > WAIT_LIMIT) begin
				fail_stop("Timeout: busy_o never fell after the sample write.");
			end
		end
	endtask

	task automatic run_update(input int r);
		kalman_fix_pkg::sample_t s;
		logic [1:0] resp;
		logic we_before;
		if (stim[r].prof != 0) begin
			write_coefs(stim[r].prof);
		end
		if (stim[r].rnd) begin
			s = kalman_fix_pkg::sample_t'($urandom);
		end else begin
			s = kalman_fix_pkg::sample_t'(stim[r].value);
		end
		model_update(s);
		got_harm.delete();
		got_pair.delete();
		axi_write(`KALMAN_ADDR_SAMPLE, to_word(s), resp);
		check_resp(resp, RESP_OKAY, "Idle sample write");
		check_busy(busy_o, 1'b1, "busy_o after the sample write");
		if (stim[r].poke) begin
			// A second sample is refused and leaves this update alone.
			axi_write(`KALMAN_ADDR_SAMPLE, to_word(-s), resp);
			check_resp(resp, RESP_SLVERR, "Sample write while busy");
		end
		wait_idle(we_before);
		check_busy(we_before, 1'b1, "state_we_o in the cycle before busy_o fell");
		if (got_harm.size() != HN) begin
			fail_stop($sformatf("MISMATCH at %0t: row %0d gave %0d stream pulses, expected %0d",
				$time, r, got_harm.size(), HN));
		end
		for (int h = 0; h < HN; h++) begin
			check_state(got_harm[h], kalman_ctrl_pkg::harm_idx_t'(h), got_pair[h], exp_pair[h],
				$sformatf("Row %0d stream", r));
		end
	endtask

	initial begin
		logic [1:0] resp;
		clk_i = 1'b0;
		harmonics_rst = 1'b1;
		s_awvalid_i = 1'b0;
		s_awaddr_i = '0;
		s_wvalid_i = 1'b0;
		s_wdata_i = '0;
		s_wstrb_i = '1;
		s_bready_i = 1'b0;
		clamp_hits = 0;
		for (int h = 0; h < HN; h++) begin
			mx1[h] = 0;
			mx2[h] = 0;
		end
		void'($urandom(48167));
		stim[0] = '{1, 1'b0, 1000, 1'b0};
		stim[1] = '{0, 1'b1, 0, 1'b0};
		stim[2] = '{2, 1'b0, 20000, 1'b0};
		stim[3] = '{0, 1'b1, 0, 1'b0};
		stim[4] = '{0, 1'b1, 0, 1'b1};
		stim[5] = '{0, 1'b0, -30000, 1'b0};
		stim[6] = '{3, 1'b0, 131071, 1'b0};
		stim[7] = '{0, 1'b0, -131072, 1'b1};
		stim[8] = '{0, 1'b1, 0, 1'b0};

		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		harmonics_rst = 1'b0;
		check_busy(busy_o, 1'b0, "busy_o after reset");
		check_busy(state_we_o, 1'b0, "state_we_o after reset");

		// Addresses outside the register map.
		axi_write(8'h20, 32'h0000_1234, resp);
		check_resp(resp, RESP_SLVERR, "Write to address 0x20");
		axi_write(8'h80, 32'h0000_5678, resp);
		check_resp(resp, RESP_SLVERR, "Write to address 0x80");

		for (int r = 0; r < STIM_N; r++) begin
			run_update(r);
		end
		if (clamp_hits == 0) begin
			fail_stop("The full-scale rows never drove a state to the 18-bit limits.");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- kalman_top.f
+incdir+rtl
rtl/kalman_fix_pkg.sv
rtl/kalman_ctrl_pkg.sv
rtl/kalman_if.sv
rtl/kalman_host_port.sv
rtl/kalman_sequencer.sv
rtl/kalman_mac.sv
rtl/kalman_state_bank.sv
rtl/kalman_top.sv
tb/kalman_tb.sv

//--- Makefile
.PHONY: run lint clean

run:
	verilator --binary --assert -f kalman_top.f --top-module kalman_tb -o kalman_sim
	@out=$$(./obj_dir/kalman_sim); echo "$$out"; echo "$$out" | grep -q "all tests passed"

lint:
	verilator --lint-only --timing --assert -f kalman_top.f --top-module kalman_tb

clean:
	rm -rf obj_dir
